//--- sources.f
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/pipe_stage.sv
design/hazard_control.sv
design/operand_fetch.sv
design/alu_stage.sv
design/mem_align.sv
design/cpu_core.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - design/cpu_isa_pkg.sv
  - design/cpu_pipe_pkg.sv
  - design/pipe_stage.sv
  - design/hazard_control.sv
  - design/operand_fetch.sv
  - design/alu_stage.sv
  - design/mem_align.sv
  - design/cpu_core.sv
  - target: simulation
    files:
      - sim/cpu_asserts.sv
      - sim/cpu_tb.sv

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	localparam cpu_isa_pkg::word_t RESET_PC = 32'h0000_0400;
	localparam int N_RAND  = 64;
	localparam int N_PROG  = N_RAND + 7;  // Random part plus final stores
	localparam int IMEM_SZ = 128;
	localparam int TIMEOUT = 2 * N_PROG + 20;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

	typedef struct packed {
		cpu_isa_pkg::word_t addr;
		cpu_isa_pkg::word_t data;
		logic [3:0]         be;
	} store_t;

	logic               clk;
	logic               rst_n;
	cpu_isa_pkg::word_t inst_addr, inst_data, mem_addr, mem_wdata, mem_rdata;
	logic [3:0]         mem_we;
	logic               mem_rd;
	logic [31:0]        imem_idx;
	logic [31:0]        lfsr;
	cpu_isa_pkg::word_t imem [0:IMEM_SZ-1];
	logic [7:0]         dmem [0:255];
	logic [7:0]         ref_mem [0:255];
	cpu_isa_pkg::word_t ref_reg [0:7];
	store_t             exp_q [$];
	int                 n_seen, cycles;

	cpu_core #(.RESET_PC(RESET_PC)) dut (.clk, .rst_n, .inst_addr, .inst_data, .mem_addr,
		.mem_wdata, .mem_we, .mem_rd, .mem_rdata);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// Memories

	assign imem_idx  = (inst_addr - RESET_PC) >> 2;
	assign inst_data = (imem_idx < IMEM_SZ) ? imem[imem_idx] : '0;  // Past the end is nop
	assign mem_rdata = {dmem[{mem_addr[7:2], 2'd3}], dmem[{mem_addr[7:2], 2'd2}],
	                    dmem[{mem_addr[7:2], 2'd1}], dmem[{mem_addr[7:2], 2'd0}]};

	always @(posedge clk) begin
		for (int i = 0; i < 4; i++)
			if (mem_we[i])
				dmem[{mem_addr[7:2], 2'(i)}] <= mem_wdata[8*i +: 8];
	end

	//////////////////////////////
	// Checking

	task automatic fail_run(string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
	endtask

	always @(negedge clk) begin
		store_t want;
		if (dut.u_asserts.n_fail != 0)
			fail_run("a bound assertion on the memory ports or the PC failed");
		if (!rst_n) begin
			compare("reset pc", RESET_PC, inst_addr);
			compare("reset strobes", 32'd0, {mem_we, mem_rd});
		end else if (mem_we != '0) begin
			if (exp_q.size() == 0) begin
				fail_run("a store appeared after all expected stores were done");
			end else begin
				want = exp_q.pop_front();
				compare($sformatf("store %0d addr", n_seen), want.addr, mem_addr);
				compare($sformatf("store %0d enables", n_seen), want.be, mem_we);
				compare($sformatf("store %0d data", n_seen), want.data, mem_wdata);
				n_seen++;
			end
		end
	end

	//////////////////////////////
	// Stimulus and model

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic cpu_isa_pkg::word_t enc_r(logic [5:0] fn, logic [2:0] rd,
	                                             logic [2:0] rs, logic [2:0] rt);
		return {cpu_isa_pkg::OP_RTYPE, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'd0, fn};
	endfunction

	function automatic cpu_isa_pkg::word_t enc_i(logic [5:0] op, logic [2:0] rt,
	                                             logic [2:0] rs, logic [15:0] imm);
		return {op, 2'b00, rs, 2'b00, rt, imm};
	endfunction

	task automatic write_reg(logic [2:0] r, cpu_isa_pkg::word_t v);
		if (r != 3'd0)
			ref_reg[r] = v;  // r0 stays zero
	endtask

	// Little endian, lane n holds byte addr+n
	task automatic expect_store(logic [7:0] addr, cpu_isa_pkg::word_t val, logic is_byte);
		store_t s;
		s.addr = {24'd0, addr[7:2], 2'b00};
		if (is_byte) begin
			s.be = 4'b0001 << addr[1:0];
			s.data = {24'd0, val[7:0]} << (8 * addr[1:0]);
			ref_mem[addr] = val[7:0];
		end else begin
			s.be = 4'b1111;
			s.data = val;
			for (int i = 0; i < 4; i++)
				ref_mem[addr + i] = val[8*i +: 8];
		end
		exp_q.push_back(s);
	endtask

	task automatic build_program();
		logic [3:0]         kind;
		logic [2:0]         rd, rs, rt;
		logic [15:0]        imm;
		logic [7:0]         addr;
		logic [5:0]         code;
		cpu_isa_pkg::word_t x, y, sx, res;
		for (int n = 0; n < N_RAND; n++) begin
			kind = 4'(rand_bits(4) % 13);
			rd = 3'(rand_bits(3));
			rs = 3'(rand_bits(3));
			rt = 3'(rand_bits(3));
			imm = 16'(rand_bits(16));
			addr = (kind == 9 || kind == 11) ? {imm[7:2], 2'b00} : imm[7:0];
			if (kind >= 8)
				rs = 3'd0;  // lui and r0-based memory accesses
			if (kind >= 9)
				imm = {8'd0, addr};
			x = ref_reg[rs];
			y = ref_reg[rt];
			sx = {{16{imm[15]}}, imm};
			case (kind)
				0:       code = cpu_isa_pkg::FN_ADDU;
				1:       code = cpu_isa_pkg::FN_SUBU;
				2:       code = cpu_isa_pkg::FN_AND;
				3:       code = cpu_isa_pkg::FN_OR;
				4:       code = cpu_isa_pkg::FN_SLT;
				5:       code = cpu_isa_pkg::OP_ADDIU;
				6:       code = cpu_isa_pkg::OP_ORI;
				7:       code = cpu_isa_pkg::OP_SLTI;
				8:       code = cpu_isa_pkg::OP_LUI;
				9:       code = cpu_isa_pkg::OP_LW;
				10:      code = cpu_isa_pkg::OP_LBU;
				11:      code = cpu_isa_pkg::OP_SW;
				default: code = cpu_isa_pkg::OP_SB;
			endcase
			imem[n] = (kind < 5) ? enc_r(code, rd, rs, rt) : enc_i(code, rt, rs, imm);
			case (kind)
				0:       res = x + y;
				1:       res = x - y;
				2:       res = x & y;
				3:       res = x | y;
				4:       res = 32'($signed(x) < $signed(y));
				5:       res = x + sx;
				6:       res = x | {16'd0, imm};
				7:       res = 32'($signed(x) < $signed(sx));
				8:       res = {imm, 16'd0};
				9:       res = {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
				10:      res = {24'd0, ref_mem[addr]};
				default: res = '0;
			endcase
			if (kind == 11 || kind == 12)
				expect_store(addr, y, kind == 12);
			else
				write_reg((kind < 5) ? rd : rt, res);
		end
		// Dump r1..r7 so every register is observed
		for (int r = 1; r < 8; r++) begin
			imem[N_RAND + r - 1] = enc_i(cpu_isa_pkg::OP_SW, 3'(r), 3'd0, 16'(8'hE0 + 4 * r));
			expect_store(8'(8'hE0 + 4 * r), ref_reg[r], 1'b0);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		lfsr = 32'd98110;
		n_seen = 0;
		for (int i = 0; i < IMEM_SZ; i++)
			imem[i] = '0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 8'(rand_bits(8));
			ref_mem[i] = dmem[i];
		end
		for (int r = 0; r < 8; r++)
			ref_reg[r] = '0;
		build_program();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		repeat (8) @(posedge clk);  // Trailing nops must not store
		@(negedge clk);
		if (exp_q.size() != 0) begin
			fail_run($sformatf("program did not finish within %0d cycles", TIMEOUT));
		end else if (dut.u_asserts.n_fail != 0) begin
			fail_run("a bound assertion on the memory ports or the PC failed");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- sim/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] inst_addr,
	input logic [3:0]  mem_we,
	input logic        mem_rd
);

	int n_fail = 0;  // Assertion failures so far

	//////////////////////////////
	// Memory port

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111})
		else begin
			$error("mem_we has an illegal lane pattern %b", mem_we);
			n_fail++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) !(mem_we != 4'b0000 && mem_rd))
		else begin
			$error("load and store strobes active together");
			n_fail++;
		end

	// Strobes stay quiet in reset
	assert property (@(posedge clk) !rst_n |-> (mem_we == 4'b0000 && !mem_rd))
		else begin
			$error("memory strobe active during reset");
			n_fail++;
		end

	//////////////////////////////
	// Fetch

	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (inst_addr == $past(inst_addr) + 32'd4 || inst_addr == $past(inst_addr)))
		else begin
			$error("inst_addr jumped from %h to %h", $past(inst_addr), inst_addr);
			n_fail++;
		end

endmodule

bind cpu_core cpu_asserts u_asserts (.clk, .rst_n, .inst_addr, .mem_we, .mem_rd);

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
	input  logic               clk,
	input  logic               rst_n,
	output cpu_isa_pkg::word_t inst_addr,
	input  cpu_isa_pkg::word_t inst_data,
	output cpu_isa_pkg::word_t mem_addr,
	output cpu_isa_pkg::word_t mem_wdata,
	output logic [3:0]         mem_we,
	output logic               mem_rd,
	input  cpu_isa_pkg::word_t mem_rdata
);

	cpu_isa_pkg::word_t     pc;
	cpu_isa_pkg::word_t     next_pc;
	cpu_isa_pkg::word_t     a, b, exe_result, load_data, mem_result;
	cpu_isa_pkg::reg_addr_t ra, rb;
	cpu_pipe_pkg::fwd_sel_e fwd_a, fwd_b;
	logic                   stall;
	cpu_pipe_pkg::if_id_t   id_d, id_q;
	cpu_pipe_pkg::id_ex_t   ctrl, ex_d, ex_q;
	cpu_pipe_pkg::ex_mem_t  mem_d, mem_q;
	cpu_pipe_pkg::mem_wb_t  wb_d, wb_q;

	//////////////////////////////
	// Fetch

	assign next_pc = pc + 32'd4;
	assign inst_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!stall)
			pc <= next_pc;
	end

	assign id_d = '{inst: inst_data, pc: pc};
	pipe_stage #(.payload_t(cpu_pipe_pkg::if_id_t)) u_if_id (.clk, .rst_n,
		.hold(stall), .bubble(1'b0), .d(id_d), .q(id_q));

	//////////////////////////////
	// Decode

	hazard_control u_hazard (.inst(id_q.inst), .ex_stage(ex_q), .mem_stage(mem_q),
		.ra, .rb, .fwd_a, .fwd_b, .stall, .ctrl);

	operand_fetch u_operands (.clk, .rst_n, .ra, .rb, .fwd_a, .fwd_b,
		.exe_result, .mem_result, .wb(wb_q), .a, .b);

	always_comb begin
		ex_d = ctrl;
		ex_d.a = a;
		ex_d.b = b;
		ex_d.store_data = b;
	end

	pipe_stage #(.payload_t(cpu_pipe_pkg::id_ex_t)) u_id_ex (.clk, .rst_n,
		.hold(1'b0), .bubble(stall), .d(ex_d), .q(ex_q));  // Stall bubble

	//////////////////////////////
	// Execute, memory, writeback

	alu_stage u_alu (.ex(ex_q), .result(exe_result));

	assign mem_d = '{result: exe_result, store_data: ex_q.store_data, mem_rd: ex_q.mem_rd,
		mem_wr: ex_q.mem_wr, mem_size: ex_q.mem_size, dest: ex_q.dest, wb_we: ex_q.wb_we};
	pipe_stage #(.payload_t(cpu_pipe_pkg::ex_mem_t)) u_ex_mem (.clk, .rst_n,
		.hold(1'b0), .bubble(1'b0), .d(mem_d), .q(mem_q));

	mem_align u_mem_align (.ex_mem(mem_q), .mem_rdata, .mem_addr, .mem_wdata,
		.mem_we, .mem_rd, .load_data);

	assign mem_result = mem_q.mem_rd ? load_data : mem_q.result;

	assign wb_d = '{data: mem_result, dest: mem_q.dest, wb_we: mem_q.wb_we};
	pipe_stage #(.payload_t(cpu_pipe_pkg::mem_wb_t)) u_mem_wb (.clk, .rst_n,
		.hold(1'b0), .bubble(1'b0), .d(wb_d), .q(wb_q));

endmodule

//--- design/mem_align.sv
`timescale 1ns/1ps

module mem_align (
	input  cpu_pipe_pkg::ex_mem_t ex_mem,
	input  cpu_isa_pkg::word_t    mem_rdata,
	output cpu_isa_pkg::word_t    mem_addr,
	output cpu_isa_pkg::word_t    mem_wdata,
	output logic [3:0]            mem_we,
	output logic                  mem_rd,
	output cpu_isa_pkg::word_t    load_data
);

	logic [1:0] lane;
	logic [7:0] rd_byte;
	logic       is_word;

	assign lane    = ex_mem.result[1:0];
	assign is_word = (ex_mem.mem_size == cpu_isa_pkg::WORD);

	assign mem_addr = {ex_mem.result[cpu_isa_pkg::XLEN-1:2], 2'b00};
	assign mem_rd   = ex_mem.mem_rd;

	//////////////////////////////
	// Store side

	always_comb begin
		if (is_word) begin
			mem_wdata = ex_mem.store_data;
			mem_we    = {4{ex_mem.mem_wr}};
		end else begin
			mem_wdata = cpu_isa_pkg::word_t'(ex_mem.store_data[7:0]) << {lane, 3'b000};
			mem_we    = {3'b000, ex_mem.mem_wr} << lane;  // One-hot lane
		end
	end

	// Load side, zero extended
	assign rd_byte   = mem_rdata[{lane, 3'b000} +: 8];
	assign load_data = is_word ? mem_rdata : cpu_isa_pkg::word_t'(rd_byte);

endmodule

//--- design/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
	input  cpu_pipe_pkg::id_ex_t ex,
	output cpu_isa_pkg::word_t   result
);

	localparam int EXT_W = cpu_isa_pkg::XLEN - cpu_isa_pkg::IMM_W;

	cpu_isa_pkg::word_t imm_ext;
	cpu_isa_pkg::word_t op_b;
	cpu_isa_pkg::word_t alu_out;

	//////////////////////////////
	// Operand B

	always_comb begin
		if (ex.sign_ext)
			imm_ext = {{EXT_W{ex.imm[cpu_isa_pkg::IMM_W-1]}}, ex.imm};
		else
			imm_ext = {{EXT_W{1'b0}}, ex.imm};  // ori zero-extends
	end

	assign op_b = ex.use_imm ? imm_ext : ex.b;

	//////////////////////////////
	// ALU

	always_comb begin
		case (ex.alu_op)
			cpu_isa_pkg::ADD: alu_out = ex.a + op_b;
			cpu_isa_pkg::SUB: alu_out = ex.a - op_b;
			cpu_isa_pkg::AND: alu_out = ex.a & op_b;
			cpu_isa_pkg::OR:  alu_out = ex.a | op_b;
			cpu_isa_pkg::SLT: begin
				// Signed compare
				alu_out = ($signed(ex.a) < $signed(op_b)) ? cpu_isa_pkg::word_t'(1) : '0;
			end
			default: alu_out = '0;
		endcase
	end

	// Loads and stores take the address from here too
	assign result = ex.is_lui ? {ex.imm, {EXT_W{1'b0}}} : alu_out;

endmodule

//--- design/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cpu_isa_pkg::reg_addr_t ra,
	input  cpu_isa_pkg::reg_addr_t rb,
	input  cpu_pipe_pkg::fwd_sel_e fwd_a,
	input  cpu_pipe_pkg::fwd_sel_e fwd_b,
	input  cpu_isa_pkg::word_t     exe_result,
	input  cpu_isa_pkg::word_t     mem_result,
	input  cpu_pipe_pkg::mem_wb_t  wb,
	output cpu_isa_pkg::word_t     a,
	output cpu_isa_pkg::word_t     b
);

	cpu_isa_pkg::word_t regs [1:cpu_isa_pkg::NREG-1];  // r0 is not stored

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < cpu_isa_pkg::NREG; i++)
				regs[i] <= '0;
		end else if (wb.wb_we && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Same-cycle writeback bypasses the array
	function automatic cpu_isa_pkg::word_t read_reg(cpu_isa_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wb.wb_we && wb.dest == addr)
			return wb.data;
		else
			return regs[addr];
	endfunction

	function automatic cpu_isa_pkg::word_t pick(cpu_pipe_pkg::fwd_sel_e sel,
	                                            cpu_isa_pkg::word_t reg_val);
		case (sel)
			cpu_pipe_pkg::EXE: return exe_result;
			cpu_pipe_pkg::MEM: return mem_result;
			default:           return reg_val;
		endcase
	endfunction

	always_comb begin
		a = pick(fwd_a, read_reg(ra));
		b = pick(fwd_b, read_reg(rb));
	end

endmodule

//--- design/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
	input  cpu_isa_pkg::word_t     inst,
	input  cpu_pipe_pkg::id_ex_t   ex_stage,
	input  cpu_pipe_pkg::ex_mem_t  mem_stage,
	output cpu_isa_pkg::reg_addr_t ra,
	output cpu_isa_pkg::reg_addr_t rb,
	output cpu_pipe_pkg::fwd_sel_e fwd_a,
	output cpu_pipe_pkg::fwd_sel_e fwd_b,
	output logic                   stall,
	output cpu_pipe_pkg::id_ex_t   ctrl
);

	logic [5:0]             opcode;
	logic [5:0]             funct;
	cpu_isa_pkg::reg_addr_t rs;
	cpu_isa_pkg::reg_addr_t rt;
	cpu_isa_pkg::reg_addr_t rd;
	logic                   use_a;
	logic                   use_b;

	assign opcode = inst[cpu_isa_pkg::OPC_LSB +: 6];
	assign funct  = inst[5:0];
	assign rs     = inst[cpu_isa_pkg::RS_LSB +: 5];
	assign rt     = inst[cpu_isa_pkg::RT_LSB +: 5];
	assign rd     = inst[cpu_isa_pkg::RD_LSB +: 5];

	//////////////////////////////
	// Decode

	always_comb begin
		ctrl = '0;
		ctrl.imm = inst[cpu_isa_pkg::IMM_W-1:0];
		ctrl.dest = (opcode == cpu_isa_pkg::OP_RTYPE) ? rd : rt;
		ctrl.wb_we = 1'b1;
		use_a = 1'b1;
		use_b = 1'b0;
		case (opcode)
			cpu_isa_pkg::OP_RTYPE: begin
				use_b = 1'b1;
				case (funct)
					cpu_isa_pkg::FN_ADDU: ctrl.alu_op = cpu_isa_pkg::ADD;
					cpu_isa_pkg::FN_SUBU: ctrl.alu_op = cpu_isa_pkg::SUB;
					cpu_isa_pkg::FN_AND:  ctrl.alu_op = cpu_isa_pkg::AND;
					cpu_isa_pkg::FN_OR:   ctrl.alu_op = cpu_isa_pkg::OR;
					cpu_isa_pkg::FN_SLT:  ctrl.alu_op = cpu_isa_pkg::SLT;
					default:              ctrl.wb_we = 1'b0;  // Unknown funct as nop
				endcase
			end
			cpu_isa_pkg::OP_ADDIU: {ctrl.use_imm, ctrl.sign_ext} = 2'b11;
			cpu_isa_pkg::OP_ORI: begin
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = cpu_isa_pkg::OR;
			end
			cpu_isa_pkg::OP_SLTI: begin
				{ctrl.use_imm, ctrl.sign_ext} = 2'b11;
				ctrl.alu_op = cpu_isa_pkg::SLT;
			end
			cpu_isa_pkg::OP_LUI: begin
				ctrl.is_lui = 1'b1;
				use_a = 1'b0;
			end
			cpu_isa_pkg::OP_LW, cpu_isa_pkg::OP_LBU: begin
				{ctrl.use_imm, ctrl.sign_ext, ctrl.mem_rd} = 3'b111;
				ctrl.mem_size = (opcode == cpu_isa_pkg::OP_LW) ? cpu_isa_pkg::WORD
				                                               : cpu_isa_pkg::BYTE;
			end
			cpu_isa_pkg::OP_SW, cpu_isa_pkg::OP_SB: begin
				{ctrl.use_imm, ctrl.sign_ext, ctrl.mem_wr} = 3'b111;
				ctrl.mem_size = (opcode == cpu_isa_pkg::OP_SW) ? cpu_isa_pkg::WORD
				                                               : cpu_isa_pkg::BYTE;
				ctrl.wb_we = 1'b0;
				use_b = 1'b1;  // rt is the store data
			end
			default: begin
				ctrl.wb_we = 1'b0;
				use_a = 1'b0;
			end
		endcase
	end

	assign ra = use_a ? rs : '0;
	assign rb = rt;

	//////////////////////////////
	// Hazards

	function automatic cpu_pipe_pkg::fwd_sel_e pick_src(cpu_isa_pkg::reg_addr_t src,
	                                                    logic used);
		if (!used || src == '0)
			return cpu_pipe_pkg::REG;
		if (ex_stage.wb_we && ex_stage.dest == src)
			return cpu_pipe_pkg::EXE;  // Youngest producer wins
		if (mem_stage.wb_we && mem_stage.dest == src)
			return cpu_pipe_pkg::MEM;
		return cpu_pipe_pkg::REG;
	endfunction

	always_comb begin
		fwd_a = pick_src(ra, use_a);
		fwd_b = pick_src(rb, use_b);
	end

	// Load data only exists one stage later
	assign stall = ex_stage.mem_rd && ex_stage.dest != '0 &&
	               ((use_a && ra == ex_stage.dest) || (use_b && rb == ex_stage.dest));

endmodule

//--- design/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!hold) begin
			// Zero payload is a nop
			q <= bubble ? payload_t'('0) : d;
		end
	end

endmodule

//--- design/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	// Operand source picked at decode
	typedef enum logic [1:0] {REG, EXE, MEM} fwd_sel_e;

	////////////////////////////////
	// Stage payloads

	typedef struct packed {
		cpu_isa_pkg::word_t inst;
		cpu_isa_pkg::word_t pc;
	} if_id_t;

	typedef struct packed {
		cpu_isa_pkg::word_t                    a;
		cpu_isa_pkg::word_t                    b;
		logic [cpu_isa_pkg::IMM_W-1:0]         imm;
		cpu_isa_pkg::alu_op_e                  alu_op;
		logic                                  use_imm;   // B from immediate
		logic                                  sign_ext;
		logic                                  is_lui;
		logic                                  mem_rd;
		logic                                  mem_wr;
		cpu_isa_pkg::mem_size_e                mem_size;
		cpu_isa_pkg::word_t                    store_data;
		cpu_isa_pkg::reg_addr_t                dest;
		logic                                  wb_we;
	} id_ex_t;

	typedef struct packed {
		cpu_isa_pkg::word_t     result;  // ALU value or byte address
		cpu_isa_pkg::word_t     store_data;
		logic                   mem_rd;
		logic                   mem_wr;
		cpu_isa_pkg::mem_size_e mem_size;
		cpu_isa_pkg::reg_addr_t dest;
		logic                   wb_we;
	} ex_mem_t;

	typedef struct packed {
		cpu_isa_pkg::word_t     data;
		cpu_isa_pkg::reg_addr_t dest;
		logic                   wb_we;
	} mem_wb_t;

endpackage

//--- design/cpu_isa_pkg.sv
package cpu_isa_pkg;

	////////////////////////////////
	// Widths

	localparam int XLEN = 32;
	localparam int NREG = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [XLEN-1:0] word_t;

	////////////////////////////////
	// Instruction fields

	localparam int OPC_LSB = 26;
	localparam int RS_LSB  = 21;
	localparam int RT_LSB  = 16;
	localparam int RD_LSB  = 11;
	localparam int IMM_W   = 16;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_LBU   = 6'h24;
	localparam logic [5:0] OP_SB    = 6'h28;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct field
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} alu_op_e;

	typedef enum logic {BYTE, WORD} mem_size_e;

endpackage
